// ==== sim.f ====
+incdir+include
hw/rvExecutePkg.sv
hw/opDecoder.sv
hw/alu.sv
hw/branchCompare.sv
hw/commitControl.sv
hw/regFile.sv
hw/executeStage.sv
verif/executeStageTb.sv

// ==== Makefile ====
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP ?= executeStageTb
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass line in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^TEST PASS$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/executeStageTb.sv ====
`default_nettype none

module executeStageTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam rvExecutePkg::opcodeT OpReg = 7'b0110011;
	localparam rvExecutePkg::opcodeT OpImm = 7'b0010011;
	localparam rvExecutePkg::opcodeT OpLui = 7'b0110111;
	localparam rvExecutePkg::opcodeT OpAuipc = 7'b0010111;
	localparam rvExecutePkg::opcodeT OpJal = 7'b1101111;
	localparam rvExecutePkg::opcodeT OpJalr = 7'b1100111;
	localparam rvExecutePkg::opcodeT OpBranch = 7'b1100011;
	localparam int TestCount = 2000;
	localparam int TimeoutCycles = TestCount + 100; // reset and drain fit easily

	logic clk;
	logic reset;
	rvExecutePkg::opcodeT opcode;
	rvExecutePkg::func3T func3;
	rvExecutePkg::func7T func7;
	rvExecutePkg::regNumT regNum0;
	rvExecutePkg::regNumT regNum1;
	rvExecutePkg::regNumT regWriteNum;
	rvExecutePkg::dataT imm;
	rvExecutePkg::dataT pc;
	logic rdWriteEnable;
	rvExecutePkg::regNumT rdWriteNum;
	rvExecutePkg::dataT rdWriteData;
	logic pcWriteEnable;
	rvExecutePkg::dataT pcWriteData;

	rvExecutePkg::dataT modelRegs [32];
	logic pendValid; // an instruction waits for its commit
	string pendName;
	logic expRdEnable;
	rvExecutePkg::regNumT expRdNum;
	rvExecutePkg::dataT expRdData;
	logic expPcEnable;
	rvExecutePkg::dataT expPcData;
	rvExecutePkg::regNumT chainRd; // rd of the last chained instruction
	int cycleCount = 0;

	executeStage UUT
	(
		.clk(clk),
		.reset(reset),
		.opcode(opcode),
		.func3(func3),
		.func7(func7),
		.regNum0(regNum0),
		.regNum1(regNum1),
		.regWriteNum(regWriteNum),
		.imm(imm),
		.pc(pc),
		.rdWriteEnable(rdWriteEnable),
		.rdWriteNum(rdWriteNum),
		.rdWriteData(rdWriteData),
		.pcWriteEnable(pcWriteEnable),
		.pcWriteData(pcWriteData)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount > TimeoutCycles)
		begin
			failRun($sformatf("timeout: no finish after %0d cycles", TimeoutCycles));
		end
	end

	task automatic failRun(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkData(input string name, input rvExecutePkg::dataT exp,
		input rvExecutePkg::dataT act);
		if (act !== exp)
		begin
			failRun($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic checkRegNum(input string name, input rvExecutePkg::regNumT exp,
		input rvExecutePkg::regNumT act);
		if (act !== exp)
		begin
			failRun($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, act));
		end
	endtask

	task automatic checkBit(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			failRun($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
		end
	endtask

	// RV32I integer ops, sub and sra picked by the alternate flags
	function automatic rvExecutePkg::dataT arithModel(input rvExecutePkg::func3T f3,
		input rvExecutePkg::dataT x, input rvExecutePkg::dataT y, input logic subFlag,
		input logic sraFlag);
		case (f3)
			3'd0: return subFlag ? x - y : x + y;
			3'd1: return x << y[4:0];
			3'd2: return rvExecutePkg::dataT'($signed(x) < $signed(y));
			3'd3: return rvExecutePkg::dataT'(x < y);
			3'd4: return x ^ y;
			3'd5: return sraFlag ? rvExecutePkg::dataT'($signed(x) >>> y[4:0]) : x >> y[4:0];
			3'd6: return x | y;
			default: return x & y;
		endcase
	endfunction

	function automatic logic branchModel(input rvExecutePkg::func3T f3,
		input rvExecutePkg::dataT a, input rvExecutePkg::dataT b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			3'd7: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic isKnownOpcode(input rvExecutePkg::opcodeT op);
		return (op == OpReg) || (op == OpImm) || (op == OpLui) || (op == OpAuipc)
			|| (op == OpJal) || (op == OpJalr) || (op == OpBranch);
	endfunction

	function automatic rvExecutePkg::dataT signExt12(input rvExecutePkg::dataT raw);
		return {{20{raw[11]}}, raw[11:0]};
	endfunction

	task automatic checkPending();
		if (pendValid)
		begin
			checkBit({pendName, " rdWriteEnable"}, expRdEnable, rdWriteEnable);
			if (expRdEnable)
			begin
				checkRegNum({pendName, " rdWriteNum"}, expRdNum, rdWriteNum);
				checkData({pendName, " rdWriteData"}, expRdData, rdWriteData);
			end
			checkBit({pendName, " pcWriteEnable"}, expPcEnable, pcWriteEnable);
			if (expPcEnable)
			begin
				checkData({pendName, " pcWriteData"}, expPcData, pcWriteData);
			end
		end
	endtask

	// checks the previous commit, drives the next instruction, predicts its commit
	task automatic issue(input string name, input rvExecutePkg::opcodeT op,
		input rvExecutePkg::func3T f3, input rvExecutePkg::func7T f7,
		input rvExecutePkg::regNumT r0, input rvExecutePkg::regNumT r1,
		input rvExecutePkg::regNumT rd, input rvExecutePkg::dataT immV,
		input rvExecutePkg::dataT pcV);
		rvExecutePkg::dataT a;
		rvExecutePkg::dataT b;
		rvExecutePkg::dataT value;
		logic writes;
		@(posedge clk);
		#1;
		checkPending();
		opcode = op;
		func3 = f3;
		func7 = f7;
		regNum0 = r0;
		regNum1 = r1;
		regWriteNum = rd;
		imm = immV;
		pc = pcV;
		a = modelRegs[r0]; // model already holds the previous write
		b = modelRegs[r1];
		writes = 1'b0;
		value = '0;
		expPcEnable = 1'b0;
		expPcData = '0;
		case (op)
			OpReg:
			begin
				writes = 1'b1;
				value = arithModel(f3, a, b, f7[5], f7[5]);
			end
			OpImm:
			begin
				writes = 1'b1;
				value = arithModel(f3, a, immV, 1'b0, immV[10]); // no subi
			end
			OpLui:
			begin
				writes = 1'b1;
				value = immV;
			end
			OpAuipc:
			begin
				writes = 1'b1;
				value = pcV + immV;
			end
			OpJal:
			begin
				writes = 1'b1;
				value = pcV + 32'd4;
				expPcEnable = 1'b1;
				expPcData = pcV + immV;
			end
			OpJalr:
			begin
				writes = 1'b1;
				value = pcV + 32'd4;
				expPcEnable = 1'b1;
				expPcData = (a + immV) & 32'hFFFF_FFFE;
			end
			OpBranch:
			begin
				expPcEnable = branchModel(f3, a, b);
				expPcData = pcV + immV;
			end
			default: writes = 1'b0;
		endcase
		expRdEnable = writes && (rd != 5'd0);
		expRdNum = rd;
		expRdData = value;
		if (expRdEnable)
		begin
			modelRegs[rd] = value;
		end
		pendName = name;
		pendValid = 1'b1;
	endtask

	task automatic randomArith(input string name, input logic chained);
		rvExecutePkg::dataT raw;
		rvExecutePkg::regNumT r0;
		rvExecutePkg::regNumT r1;
		rvExecutePkg::regNumT rd;
		raw = $urandom;
		r0 = rvExecutePkg::regNumT'($urandom_range(31, 0));
		r1 = rvExecutePkg::regNumT'($urandom_range(31, 0));
		rd = rvExecutePkg::regNumT'($urandom_range(31, 0)); // x0 included
		if (chained)
		begin
			if (raw[13] || !raw[12])
				r0 = chainRd;
			else
				r1 = chainRd;
			rd = rvExecutePkg::regNumT'($urandom_range(31, 1)); // needs a real write
		end
		if (raw[12])
			issue(name, OpReg, raw[16:14], {1'b0, raw[17], 5'b0}, r0, r1, rd, '0, '0);
		else
			issue(name, OpImm, raw[16:14], '0, r0, r1, rd, signExt12($urandom), '0);
		chainRd = rd;
	endtask

	initial
	begin
		rvExecutePkg::dataT raw;
		rvExecutePkg::dataT pcV;
		rvExecutePkg::opcodeT op;
		rvExecutePkg::regNumT r0;
		rvExecutePkg::func3T branchCodes [6];
		void'($urandom(32'h2f32faef));
		branchCodes = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		reset = 1'b1;
		opcode = '0;
		func3 = '0;
		func7 = '0;
		regNum0 = '0;
		regNum1 = '0;
		regWriteNum = '0;
		imm = '0;
		pc = '0;
		pendValid = 1'b0;
		chainRd = 5'd1;
		for (int i = 0; i < 32; i++)
			modelRegs[i] = '0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		for (int i = 0; i < 4; i++)
			issue("idle after reset", '0, '0, '0, '0, '0, '0, '0, '0);
		for (int i = 0; i < 32; i++) // every register reads zero on both ports
			issue("zero read", OpReg, 3'd0, '0, rvExecutePkg::regNumT'(i),
				rvExecutePkg::regNumT'(31 - i), rvExecutePkg::regNumT'($urandom_range(31, 1)),
				'0, '0);
		issue("addi zero", OpImm, 3'd0, '0, 5'd7, '0, 5'd3, '0, '0);

		for (int i = 0; i < 200; i++)
		begin
			raw = $urandom;
			pcV = $urandom & 32'hFFFF_FFFC;
			if (raw[0])
				issue("lui", OpLui, '0, '0, '0, '0, rvExecutePkg::regNumT'($urandom_range(31, 0)),
					{raw[31:12], 12'b0}, pcV);
			else
				issue("auipc", OpAuipc, '0, '0, '0, '0,
					rvExecutePkg::regNumT'($urandom_range(31, 0)), {raw[31:12], 12'b0}, pcV);
		end
		for (int i = 0; i < 900; i++)
			randomArith("random arith", 1'b0);
		for (int i = 0; i < 300; i++)
			randomArith("forwarding chain", 1'b1);

		for (int i = 0; i < 200; i++)
		begin
			raw = $urandom;
			pcV = $urandom & 32'hFFFF_FFFC;
			if (i % 2 == 0)
				issue("jal", OpJal, '0, '0, '0, '0, rvExecutePkg::regNumT'($urandom_range(31, 0)),
					{{11{raw[20]}}, raw[20:1], 1'b0}, pcV);
			else // odd targets test the bit 0 clear
				issue("jalr", OpJalr, '0, '0, rvExecutePkg::regNumT'($urandom_range(31, 0)), '0,
					rvExecutePkg::regNumT'($urandom_range(31, 0)), signExt12(raw), pcV);
		end
		for (int i = 0; i < 300; i++)
		begin
			raw = $urandom;
			pcV = $urandom & 32'hFFFF_FFFC;
			r0 = rvExecutePkg::regNumT'($urandom_range(31, 0));
			issue("branch", OpBranch, branchCodes[$urandom_range(5, 0)], '0, r0,
				raw[0] ? r0 : rvExecutePkg::regNumT'($urandom_range(31, 0)), '0,
				{{19{raw[12]}}, raw[12:1], 1'b0}, pcV);
		end
		for (int i = 0; i < 63; i++)
		begin
			raw = $urandom;
			if (i % 2 == 0)
			begin
				do
					op = rvExecutePkg::opcodeT'($urandom_range(127, 0));
				while (isKnownOpcode(op));
				issue("unknown opcode", op, raw[2:0], '0, raw[7:3], raw[12:8], raw[17:13],
					raw, 32'h0000_1000);
			end
			else
				issue("branch func3 2 or 3", OpBranch, {2'b01, raw[0]}, '0, raw[7:3], raw[12:8],
					'0, 32'h0000_0040, 32'h0000_2000);
		end

		@(posedge clk);
		#1;
		checkPending(); // last commit
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/executeStage.sv ====
`default_nettype none

module executeStage
(
	input logic clk,
	input logic reset,
	input rvExecutePkg::opcodeT opcode,
	input rvExecutePkg::func3T func3,
	input rvExecutePkg::func7T func7,
	input rvExecutePkg::regNumT regNum0,
	input rvExecutePkg::regNumT regNum1,
	input rvExecutePkg::regNumT regWriteNum,
	input rvExecutePkg::dataT imm,
	input rvExecutePkg::dataT pc,
	output logic rdWriteEnable,
	output rvExecutePkg::regNumT rdWriteNum,
	output rvExecutePkg::dataT rdWriteData,
	output logic pcWriteEnable,
	output rvExecutePkg::dataT pcWriteData
);

	rvExecutePkg::aluOpT aluOp;
	rvExecutePkg::commitKindT commitKind;
	logic selPcX;
	logic selImmY;
	logic jumpReg;
	logic taken;
	rvExecutePkg::dataT readData0;
	rvExecutePkg::dataT readData1;
	rvExecutePkg::dataT aluX;
	rvExecutePkg::dataT aluY;
	rvExecutePkg::dataT aluResult;

	assign aluX = selPcX ? pc : readData0;
	assign aluY = selImmY ? imm : readData1;

	opDecoder decoder
	(
		.opcode(opcode),
		.func3(func3),
		.func7(func7),
		.immBit10(imm[10]), // srai flag
		.aluOp(aluOp),
		.selPcX(selPcX),
		.selImmY(selImmY),
		.commitKind(commitKind),
		.jumpReg(jumpReg)
	);

	regFile rf
	(
		.clk(clk),
		.reset(reset),
		.readNum0(regNum0),
		.readNum1(regNum1),
		.writeEnable(rdWriteEnable), // written back from the commit register
		.writeNum(rdWriteNum),
		.writeData(rdWriteData),
		.readData0(readData0),
		.readData1(readData1)
	);

	alu arith
	(
		.aluOp(aluOp),
		.x(aluX),
		.y(aluY),
		.result(aluResult)
	);

	branchCompare cmp
	(
		.func3(func3),
		.a(readData0),
		.b(readData1),
		.taken(taken)
	);

	commitControl commit
	(
		.clk(clk),
		.reset(reset),
		.commitKind(commitKind),
		.jumpReg(jumpReg),
		.taken(taken),
		.aluResult(aluResult),
		.imm(imm),
		.pc(pc),
		.regWriteNum(regWriteNum),
		.rdWriteEnable(rdWriteEnable),
		.rdWriteNum(rdWriteNum),
		.rdWriteData(rdWriteData),
		.pcWriteEnable(pcWriteEnable),
		.pcWriteData(pcWriteData)
	);

endmodule

`default_nettype wire

// ==== hw/regFile.sv ====
`default_nettype none

`include "rvExecute_config.svh"

module regFile
(
	input logic clk,
	input logic reset,
	input rvExecutePkg::regNumT readNum0,
	input rvExecutePkg::regNumT readNum1,
	input logic writeEnable,
	input rvExecutePkg::regNumT writeNum,
	input rvExecutePkg::dataT writeData,
	output rvExecutePkg::dataT readData0,
	output rvExecutePkg::dataT readData1
);

	rvExecutePkg::dataT regs [`RvRegCount];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `RvRegCount; i++)
			begin
				regs[i] <= '0; // x0 keeps this forever
			end
		end
		else if (writeEnable)
		begin
			regs[writeNum] <= writeData;
		end
	end

	// pending commit bypasses the array
	assign readData0 = (writeEnable && (writeNum == readNum0)) ? writeData : regs[readNum0];
	assign readData1 = (writeEnable && (writeNum == readNum1)) ? writeData : regs[readNum1];

endmodule

`default_nettype wire

// ==== hw/commitControl.sv ====
`default_nettype none

module commitControl
(
	input logic clk,
	input logic reset,
	input rvExecutePkg::commitKindT commitKind,
	input logic jumpReg,
	input logic taken,
	input rvExecutePkg::dataT aluResult,
	input rvExecutePkg::dataT imm,
	input rvExecutePkg::dataT pc,
	input rvExecutePkg::regNumT regWriteNum,
	output logic rdWriteEnable,
	output rvExecutePkg::regNumT rdWriteNum,
	output rvExecutePkg::dataT rdWriteData,
	output logic pcWriteEnable,
	output rvExecutePkg::dataT pcWriteData
);

	logic writesRd;
	logic nextRdEnable;
	logic nextPcEnable;
	rvExecutePkg::dataT nextRdData;
	rvExecutePkg::dataT nextPcData;

	assign writesRd = (commitKind == rvExecutePkg::commitRegWrite)
		|| (commitKind == rvExecutePkg::commitImmWrite)
		|| (commitKind == rvExecutePkg::commitLink);
	assign nextRdEnable = writesRd && (regWriteNum != '0); // x0 never written
	assign nextPcEnable = (commitKind == rvExecutePkg::commitLink)
		|| ((commitKind == rvExecutePkg::commitBranch) && taken);
	// jalr drops bit 0 of its target
	assign nextPcData = jumpReg ? (aluResult & ~rvExecutePkg::dataT'(1)) : aluResult;

	always_comb
	begin
		case (commitKind)
			rvExecutePkg::commitImmWrite: nextRdData = imm; // lui
			rvExecutePkg::commitLink: nextRdData = pc + rvExecutePkg::dataT'(4); // return address
			default: nextRdData = aluResult;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rdWriteEnable <= 1'b0;
			pcWriteEnable <= 1'b0;
		end
		else
		begin
			rdWriteEnable <= nextRdEnable;
			pcWriteEnable <= nextPcEnable;
		end
	end

	always_ff @(posedge clk)
	begin
		rdWriteNum <= regWriteNum;
		rdWriteData <= nextRdData;
		pcWriteData <= nextPcData;
	end

endmodule

`default_nettype wire

// ==== hw/branchCompare.sv ====
`default_nettype none

module branchCompare
(
	input rvExecutePkg::func3T func3,
	input rvExecutePkg::dataT a,
	input rvExecutePkg::dataT b,
	output logic taken
);

	logic equal;
	logic lessSigned;
	logic lessUnsigned;

	assign equal = (a == b);
	assign lessSigned = ($signed(a) < $signed(b));
	assign lessUnsigned = (a < b);

	always_comb
	begin
		case (func3)
			3'd0: taken = equal; // beq
			3'd1: taken = !equal; // bne
			3'd4: taken = lessSigned; // blt
			3'd5: taken = !lessSigned; // bge
			3'd6: taken = lessUnsigned; // bltu
			3'd7: taken = !lessUnsigned; // bgeu
			default: taken = 1'b0; // codes 2 and 3 are not branches
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
`default_nettype none

`include "rvExecute_config.svh"

module alu
(
	input rvExecutePkg::aluOpT aluOp,
	input rvExecutePkg::dataT x,
	input rvExecutePkg::dataT y,
	output rvExecutePkg::dataT result
);

	localparam int ShiftWidth = $clog2(`RvDataWidth);

	logic [ShiftWidth-1:0] shamt;

	assign shamt = y[ShiftWidth-1:0]; // only the low bits count

	always_comb
	begin
		result = '0;
		case (aluOp)
			rvExecutePkg::aluAdd: result = x + y;
			rvExecutePkg::aluSub: result = x - y;
			rvExecutePkg::aluSll: result = x << shamt;
			rvExecutePkg::aluSrl: result = x >> shamt;
			rvExecutePkg::aluSra: result = rvExecutePkg::dataT'($signed(x) >>> shamt);
			rvExecutePkg::aluSlt: result = rvExecutePkg::dataT'($signed(x) < $signed(y));
			rvExecutePkg::aluSltu: result = rvExecutePkg::dataT'(x < y);
			rvExecutePkg::aluXor: result = x ^ y;
			rvExecutePkg::aluOr: result = x | y;
			rvExecutePkg::aluAnd: result = x & y;
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/opDecoder.sv ====
`default_nettype none

module opDecoder
(
	input rvExecutePkg::opcodeT opcode,
	input rvExecutePkg::func3T func3,
	input rvExecutePkg::func7T func7,
	input logic immBit10,
	output rvExecutePkg::aluOpT aluOp,
	output logic selPcX, // operand x from pc instead of source 0
	output logic selImmY, // operand y from imm instead of source 1
	output rvExecutePkg::commitKindT commitKind,
	output logic jumpReg // jalr
);

	localparam rvExecutePkg::opcodeT OpReg = 7'b0110011;
	localparam rvExecutePkg::opcodeT OpImm = 7'b0010011;
	localparam rvExecutePkg::opcodeT OpLui = 7'b0110111;
	localparam rvExecutePkg::opcodeT OpAuipc = 7'b0010111;
	localparam rvExecutePkg::opcodeT OpJal = 7'b1101111;
	localparam rvExecutePkg::opcodeT OpJalr = 7'b1100111;
	localparam rvExecutePkg::opcodeT OpBranch = 7'b1100011;

	// shared func3 table of the R and I formats
	function automatic rvExecutePkg::aluOpT arithOp
	(
		input rvExecutePkg::func3T f3,
		input logic alt, // func7[5] or imm[10]
		input logic isReg // sub exists only in the R format
	);
		arithOp = rvExecutePkg::aluAdd;
		case (f3)
			3'd0: arithOp = (alt && isReg) ? rvExecutePkg::aluSub : rvExecutePkg::aluAdd;
			3'd1: arithOp = rvExecutePkg::aluSll;
			3'd2: arithOp = rvExecutePkg::aluSlt;
			3'd3: arithOp = rvExecutePkg::aluSltu;
			3'd4: arithOp = rvExecutePkg::aluXor;
			3'd5: arithOp = alt ? rvExecutePkg::aluSra : rvExecutePkg::aluSrl;
			3'd6: arithOp = rvExecutePkg::aluOr;
			3'd7: arithOp = rvExecutePkg::aluAnd;
			default: arithOp = rvExecutePkg::aluAdd;
		endcase
	endfunction

	always_comb
	begin
		aluOp = rvExecutePkg::aluAdd; // sums for addresses and targets
		selPcX = 1'b0;
		selImmY = 1'b0;
		commitKind = rvExecutePkg::commitNone;
		jumpReg = 1'b0;
		case (opcode)
			OpReg:
			begin
				aluOp = arithOp(func3, func7[5], 1'b1);
				commitKind = rvExecutePkg::commitRegWrite;
			end
			OpImm:
			begin
				aluOp = arithOp(func3, immBit10, 1'b0);
				selImmY = 1'b1;
				commitKind = rvExecutePkg::commitRegWrite;
			end
			OpLui: commitKind = rvExecutePkg::commitImmWrite; // alu unused
			OpAuipc:
			begin
				selPcX = 1'b1;
				selImmY = 1'b1;
				commitKind = rvExecutePkg::commitRegWrite;
			end
			OpJal:
			begin
				selPcX = 1'b1;
				selImmY = 1'b1;
				commitKind = rvExecutePkg::commitLink;
			end
			OpJalr:
			begin
				selImmY = 1'b1; // rs1 + imm
				commitKind = rvExecutePkg::commitLink;
				jumpReg = 1'b1;
			end
			OpBranch:
			begin
				selPcX = 1'b1; // alu makes the target, comparator decides
				selImmY = 1'b1;
				commitKind = rvExecutePkg::commitBranch;
			end
			default: commitKind = rvExecutePkg::commitNone;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/rvExecutePkg.sv ====
`default_nettype none

`include "rvExecute_config.svh"

package rvExecutePkg;

	typedef logic [`RvDataWidth-1:0] dataT; // data word or address
	typedef logic [`RvRegNumWidth-1:0] regNumT;
	typedef logic [6:0] opcodeT;
	typedef logic [2:0] func3T;
	typedef logic [6:0] func7T;

	typedef enum logic [3:0]
	{
		aluAdd,
		aluSub,
		aluSll,
		aluSrl,
		aluSra,
		aluSlt, // signed compare
		aluSltu, // unsigned compare
		aluXor,
		aluOr,
		aluAnd
	} aluOpT;

	typedef enum logic [2:0]
	{
		commitNone, // unknown opcode, nothing retires
		commitRegWrite, // alu result to rd
		commitImmWrite, // lui
		commitLink, // pc + 4 to rd and jump
		commitBranch // conditional redirect
	} commitKindT;

endpackage

`default_nettype wire

// ==== include/rvExecute_config.svh ====
`ifndef RV_EXECUTE_CONFIG_SVH
`define RV_EXECUTE_CONFIG_SVH

// datapath sizing for the execute stage

// data word and address width
`define RvDataWidth 32

// architectural registers, x0 included
`define RvRegCount 32

// bits needed to name one register
`define RvRegNumWidth 5

`endif
